/* run_sim.sh */
#!/bin/sh
# Build and run the ICCM testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_iccm_mem -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_iccm_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: PASS" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* sim/iccm_mem_asserts.sv */
// ICCM top level assertions
`default_nettype none

module iccm_mem_asserts
   import iccm_pkg::*;
(
   input logic             clk,
   input logic             rst_n,
   input iccm_req_t        req,
   input logic [63:0]      rd_data,
   input iccm_row_t [1:0]  rows
);
   timeunit 1ns;
   timeprecision 100ps;

   // **************************************************
   // Request and read path
   // **************************************************
   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(req.rden && req.wren))
      else $error("rden and wren high together");

   // Unaligned return has zero top halfword
   a_rd_top_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (req.rden && req.addr[0]) |=> (rd_data[63:48] == 16'h0))
      else $error("rd_data upper halfword not zero");

   // Spare rows hold distinct words
   a_rows_unique: assert property (@(posedge clk) disable iff (!rst_n)
      !(rows[0].valid && rows[1].valid && (rows[0].waddr == rows[1].waddr)))
      else $error("both spare rows hold the same word address");

endmodule

bind iccm_mem iccm_mem_asserts i_iccm_mem_asserts (
   .clk, .rst_n, .req, .rd_data, .rows
);

`default_nettype wire

/* sim/tb_iccm_mem.sv */
// ICCM memory testbench
`default_nettype none

module tb_iccm_mem
   import iccm_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ICCM_BITS = 12;
   localparam int NUM_WORDS = 2**(ICCM_BITS-2);
   localparam int EDGE_TIMEOUT = 2000;   // In 1 ns polling steps

   // Operation kinds in the stimulus table
   localparam logic [1:0] K_WR = 2'd0;
   localparam logic [1:0] K_RD = 2'd1;
   localparam logic [1:0] K_CORR = 2'd2;     // Correction alone
   localparam logic [1:0] K_WRCORR = 2'd3;   // Correction with bank write

   typedef struct packed {
      logic [1:0]           kind;
      iccm_size_e           size;
      logic                 corr_state;
      logic [ICCM_BITS-2:0] addr;
      iccm_word_t           hi;
      iccm_word_t           lo;
      logic [63:0]          exp_data;    // Filled from the model
      logic [77:0]          exp_ecc;
   } op_t;

   logic        clk;
   logic        rst_n;
   iccm_req_t   req;
   iccm_wdata_t wr_data;
   logic [63:0] rd_data;
   logic [77:0] rd_data_ecc;

   op_t        ops[$];
   iccm_word_t ref_mem [NUM_WORDS];    // Bank contents
   logic       sp_valid [2];           // Spare row model
   int         sp_waddr [2];
   iccm_word_t sp_data [2];
   logic       sp_lru;
   int         seed = 32'hc380;
   int         cyc = 0;
   int         errors = 0;
   int         checks = 0;

   iccm_mem #(.ICCM_BITS(ICCM_BITS)) i_iccm_mem (
      .clk, .rst_n, .req, .wr_data, .rd_data, .rd_data_ecc
   );

   always #50 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   // **************************************************
   // Helpers
   // **************************************************
   function automatic iccm_word_t rand_word();
      iccm_word_t w;
      w[31:0] = $random(seed);
      w[38:32] = 7'($random(seed));   // Check bits
      return w;
   endfunction

   // Poll until the next rising edge has passed
   task automatic wait_edge();
      int start;
      int n;
      start = cyc;
      n = 0;
      while (cyc == start && n < EDGE_TIMEOUT) begin
         #1;
         n++;
      end
      if (cyc == start) begin
         $display("Timeout: no clock edge seen while waiting");
         $display("RESULT: FAIL");
         $finish;
      end
   endtask

   task automatic add_op(input logic [1:0] kind, input iccm_size_e size,
                         input logic corr, input int addr);
      op_t o;
      o = '0;
      o.kind = kind;
      o.size = size;
      o.corr_state = corr;
      o.addr = (ICCM_BITS-1)'(addr);
      o.hi = rand_word();
      o.lo = rand_word();
      ops.push_back(o);
   endtask

   // Spare data wins over bank data
   function automatic iccm_word_t word_at(int w);
      if (sp_valid[1] && sp_waddr[1] == w) return sp_data[1];
      if (sp_valid[0] && sp_waddr[0] == w) return sp_data[0];
      return ref_mem[w];
   endfunction

   task automatic model_write(input op_t o);
      int w;
      w = int'(o.addr) >> 1;
      if (o.size == SZ_DW) begin
         ref_mem[w] = o.lo;          // Even bank
         ref_mem[w+1] = o.hi;
      end else begin
         ref_mem[w] = w[0] ? o.hi : o.lo;
      end
      for (int r = 0; r < 2; r++) begin
         if (sp_valid[r] && (sp_waddr[r] == w || (o.size == SZ_DW && sp_waddr[r] == w + 1)))
            sp_data[r] = ref_mem[sp_waddr[r]];
      end
   endtask

   task automatic model_read(inout op_t o);
      int w0;
      int w1;
      iccm_word_t d0;
      iccm_word_t d1;
      logic hit0;
      logic hit1;
      w0 = int'(o.addr) >> 1;
      w1 = o.addr[0] ? (w0 + 1) % NUM_WORDS : w0;
      d0 = word_at(w0);
      d1 = word_at(w1);
      o.exp_ecc = {d1, d0};
      if (o.addr[0]) o.exp_data = {16'h0, d1[31:0], d0[31:16]};
      else o.exp_data = {d1[31:0], d0[31:0]};
      hit0 = sp_valid[0] && (sp_waddr[0] == w0 || sp_waddr[0] == w1);
      hit1 = sp_valid[1] && (sp_waddr[1] == w0 || sp_waddr[1] == w1);
      if (o.corr_state && (hit0 || hit1)) sp_lru = hit0;  // Steer off the hit row
   endtask

   // **************************************************
   // Stimulus table and run
   // **************************************************
   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      req = '0;
      req.size = SZ_WORD;
      wr_data = '0;
      sp_valid = '{1'b0, 1'b0};
      sp_waddr = '{0, 0};
      sp_lru = 1'b0;

      add_op(K_WR, SZ_DW, 0, 0);       // Words 0 and 1
      add_op(K_WR, SZ_DW, 0, 4);       // Words 2 and 3
      add_op(K_WR, SZ_WORD, 0, 8);     // Word 4
      add_op(K_WR, SZ_WORD, 0, 10);
      add_op(K_WR, SZ_WORD, 0, 12);
      add_op(K_WR, SZ_WORD, 0, 14);    // Word 7, bank 3
      add_op(K_WR, SZ_DW, 0, 16);      // Words 8 and 9
      add_op(K_RD, SZ_WORD, 0, 0);
      add_op(K_RD, SZ_WORD, 0, 2);
      add_op(K_RD, SZ_WORD, 0, 4);
      add_op(K_RD, SZ_WORD, 0, 6);
      add_op(K_RD, SZ_WORD, 0, 8);
      add_op(K_RD, SZ_WORD, 0, 14);
      add_op(K_RD, SZ_WORD, 0, 1);     // Unaligned
      add_op(K_RD, SZ_WORD, 0, 7);     // Bank 3 into next row
      add_op(K_RD, SZ_WORD, 0, 15);
      add_op(K_CORR, SZ_WORD, 1, 10);  // Word 5 into row 0
      add_op(K_RD, SZ_WORD, 0, 10);
      add_op(K_RD, SZ_WORD, 0, 9);
      add_op(K_RD, SZ_WORD, 0, 12);
      add_op(K_WR, SZ_WORD, 0, 10);    // Repaired word rewritten
      add_op(K_RD, SZ_WORD, 0, 10);
      add_op(K_CORR, SZ_WORD, 1, 12);  // Word 6 into row 1
      add_op(K_RD, SZ_WORD, 0, 12);
      add_op(K_CORR, SZ_WORD, 1, 4);   // Evicts word 5
      add_op(K_RD, SZ_WORD, 0, 10);
      add_op(K_RD, SZ_WORD, 1, 12);    // Hit on row 1 points LRU at row 0
      add_op(K_RD, SZ_WORD, 1, 4);     // Hit on row 0 in correction
      add_op(K_CORR, SZ_WORD, 1, 6);   // Replaces row 1
      add_op(K_RD, SZ_WORD, 0, 12);
      add_op(K_RD, SZ_WORD, 0, 6);
      add_op(K_RD, SZ_WORD, 0, 5);
      add_op(K_WRCORR, SZ_WORD, 1, 14);
      add_op(K_RD, SZ_WORD, 0, 14);
      add_op(K_RD, SZ_WORD, 0, 4);

      repeat (4) wait_edge();
      rst_n = 1'b1;

      foreach (ops[i]) begin
         op_t o;
         logic ok;
         o = ops[i];
         ok = 1'b1;
         req = '0;
         req.size = o.size;
         req.addr = o.addr;
         req.corr_state = o.corr_state;
         req.wren = (o.kind == K_WR) || (o.kind == K_WRCORR);
         req.rden = (o.kind == K_RD);
         req.correct = (o.kind == K_CORR) || (o.kind == K_WRCORR);
         wr_data.hi = o.hi;
         wr_data.lo = o.lo;

         // Model follows the same request
         if (req.wren) model_write(o);
         if (req.correct) begin
            sp_valid[sp_lru] = 1'b1;
            sp_waddr[sp_lru] = int'(o.addr) >> 1;
            sp_data[sp_lru] = o.lo;
            sp_lru = ~sp_lru;
         end
         if (req.rden) model_read(o);
         ops[i] = o;

         wait_edge();                  // Strobe edge
         req = '0;
         req.size = SZ_WORD;
         if (o.kind == K_RD) begin
            checks++;
            if (rd_data !== o.exp_data) begin
               $display("MISMATCH time=%0t signal=rd_data expected=%h actual=%h",
                        $time, o.exp_data, rd_data);
               ok = 1'b0;
            end
            if (rd_data_ecc !== o.exp_ecc) begin
               $display("MISMATCH time=%0t signal=rd_data_ecc expected=%h actual=%h",
                        $time, o.exp_ecc, rd_data_ecc);
               ok = 1'b0;
            end
            if (!ok) errors++;
         end
         $display("Test %0d kind %0d addr %h: %s", i, o.kind, o.addr, ok ? "ok" : "failed");
      end

      wait_edge();
      $display("Done: %0d operations, %0d read checks, %0d errors", ops.size(), checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/iccm_bank.sv */
// ICCM single port bank
`default_nettype none

module iccm_bank
   import iccm_pkg::*;
#(
   parameter int ROW_BITS = ICCM_BITS_DEF - 4
) (
   input  logic                clk,
   input  logic                en,     // Chip enable
   input  logic                we,
   input  logic [ROW_BITS-1:0] addr,
   input  iccm_word_t          wdata,
   output iccm_word_t          dout
);

   // Behavioural array, one word per row
   iccm_word_t mem [2**ROW_BITS];

   // **************************************************
   // Access port
   // **************************************************
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;  // Write leaves dout alone
         end else begin
            dout <= mem[addr];   // Registered read
         end
      end
   end

endmodule

`default_nettype wire

/* source/iccm_bank_ctrl.sv */
// ICCM bank enable and address steering
`default_nettype none

module iccm_bank_ctrl
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = ICCM_BITS_DEF
) (
   input  iccm_req_t                                  req,
   input  iccm_wdata_t                                wr_data,
   output logic       [NUM_BANKS-1:0]                 bank_en,
   output logic       [NUM_BANKS-1:0]                 bank_we,
   output logic       [NUM_BANKS-1:0][ICCM_BITS-5:0]  bank_addr,
   output iccm_word_t [NUM_BANKS-1:0]                 bank_wdata,
   output logic       [ICCM_BITS-2:0]                 inc_addr
);

   // Bit positions within the halfword address
   localparam int BSEL_LO = BANK_LO - 1;
   localparam int ROW_LO = BANK_LO + BANK_BITS - 1;

   logic [1:0]           incr;     // Halfwords to second word
   logic [NUM_BANKS-1:0] hit_lo;   // Bank picked by request address
   logic [NUM_BANKS-1:0] hit_inc;  // Bank picked by incremented address

   // DW write steps a full word, reads step one halfword
   assign incr = (req.wren && (req.size == SZ_DW)) ? 2'd2 : 2'd1;
   assign inc_addr = req.addr + {{(ICCM_BITS-3){1'b0}}, incr};

   // **************************************************
   // Per bank controls
   // **************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign hit_lo[i] = (req.addr[BSEL_LO +: BANK_BITS] == BANK_BITS'(i));
      assign hit_inc[i] = (inc_addr[BSEL_LO +: BANK_BITS] == BANK_BITS'(i));

      assign bank_we[i] = req.wren & (hit_lo[i] | hit_inc[i]);
      assign bank_en[i] = (req.wren | req.rden) & (hit_lo[i] | hit_inc[i]);

      // Writes stay in the request row since DW is 8 byte aligned
      // Read wrap from bank 3 lands in the next row of bank 0
      assign bank_addr[i] = (bank_we[i] || !hit_inc[i]) ?
                            req.addr[ICCM_BITS-2:ROW_LO] :
                            inc_addr[ICCM_BITS-2:ROW_LO];

      // Low word to even banks
      assign bank_wdata[i] = ((i % 2) == 0) ? wr_data.lo : wr_data.hi;
   end

endmodule

`default_nettype wire

/* source/iccm_mem.sv */
// ICCM top level
`default_nettype none

module iccm_mem
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = ICCM_BITS_DEF
) (
   input  logic         clk,
   input  logic         rst_n,
   input  iccm_req_t    req,
   input  iccm_wdata_t  wr_data,
   output logic [63:0]  rd_data,
   output logic [77:0]  rd_data_ecc
);

   localparam int ROW_BITS = ICCM_BITS - 4;  // Rows per bank

   // Package structs are sized for the default depth
   if (ICCM_BITS != ICCM_BITS_DEF) begin : g_bits_chk
      $error("ICCM_BITS %0d differs from package width %0d", ICCM_BITS, ICCM_BITS_DEF);
   end

   logic       [NUM_BANKS-1:0]                bank_en;
   logic       [NUM_BANKS-1:0]                bank_we;
   logic       [NUM_BANKS-1:0][ROW_BITS-1:0]  bank_addr;
   iccm_word_t [NUM_BANKS-1:0]                bank_wdata;
   iccm_word_t [NUM_BANKS-1:0]                bank_dout;
   logic       [ICCM_BITS-2:0]                inc_addr;
   iccm_row_t  [1:0]                          rows;
   logic       [NUM_BANKS-1:0]                sel0_q;
   logic       [NUM_BANKS-1:0]                sel1_q;

   // **************************************************
   // Control, array and spare rows
   // **************************************************
   iccm_bank_ctrl #(.ICCM_BITS(ICCM_BITS)) i_bank_ctrl (
      .req, .wr_data, .bank_en, .bank_we, .bank_addr, .bank_wdata, .inc_addr
   );

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      iccm_bank #(.ROW_BITS(ROW_BITS)) i_bank (
         .clk,
         .en    (bank_en[i]),
         .we    (bank_we[i]),
         .addr  (bank_addr[i]),
         .wdata (bank_wdata[i]),
         .dout  (bank_dout[i])
      );
   end

   iccm_red_rows #(.ICCM_BITS(ICCM_BITS)) i_red_rows (
      .clk, .rst_n, .req, .wr_data, .inc_addr, .rows, .sel0_q, .sel1_q
   );

   // Read return path
   iccm_rd_align #(.ICCM_BITS(ICCM_BITS)) i_rd_align (
      .clk,
      .rst_n,
      .rden     (req.rden),
      .req_addr (req.addr),
      .inc_addr,
      .bank_dout,
      .rows,
      .sel0_q,
      .sel1_q,
      .rd_data,
      .rd_data_ecc
   );

endmodule

`default_nettype wire

/* source/iccm_pkg.sv */
// ICCM shared types and constants
`default_nettype none

package iccm_pkg;

   // **************************************************
   // Geometry
   // **************************************************
   localparam int NUM_BANKS = 4;  // Interleaved banks
   localparam int BANK_LO = 2;    // Lowest bank select bit, byte address
   localparam int BANK_BITS = 2;
   localparam int DATA_W = 32;
   localparam int WORD_W = 39;    // Data plus 7 check bits

   // Struct widths follow this value
   localparam int ICCM_BITS_DEF = 12;

   // Write size encodings
   typedef enum logic [1:0] {
      SZ_WORD = 2'b10,
      SZ_DW   = 2'b11
   } iccm_size_e;

   typedef logic [WORD_W-1:0] iccm_word_t;

   // Even banks take lo, odd banks take hi
   typedef struct packed {
      iccm_word_t hi;
      iccm_word_t lo;
   } iccm_wdata_t;

   // One fetch side request
   typedef struct packed {
      logic                     wren;
      logic                     rden;
      logic                     correct;     // Spare row load strobe
      logic                     corr_state;  // Correction sequence in flight
      iccm_size_e               size;
      logic [ICCM_BITS_DEF-2:0] addr;        // Halfword address
   } iccm_req_t;

   // Hard fault spare row
   typedef struct packed {
      logic                     valid;
      logic [ICCM_BITS_DEF-3:0] waddr;       // Word address
      iccm_word_t               data;
   } iccm_row_t;

endpackage

`default_nettype wire

/* source/iccm_rd_align.sv */
// ICCM read data override and alignment
`default_nettype none

module iccm_rd_align
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = ICCM_BITS_DEF
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        rden,
   input  logic       [ICCM_BITS-2:0]  req_addr,
   input  logic       [ICCM_BITS-2:0]  inc_addr,
   input  iccm_word_t [NUM_BANKS-1:0]  bank_dout,
   input  iccm_row_t  [1:0]            rows,
   input  logic       [NUM_BANKS-1:0]  sel0_q,
   input  logic       [NUM_BANKS-1:0]  sel1_q,
   output logic       [63:0]           rd_data,
   output logic       [77:0]           rd_data_ecc
);

   localparam int BSEL_LO = BANK_LO - 1;

   logic [BANK_BITS:0]         lo_q;     // Low bank index and halfword bit
   logic [BANK_BITS-1:0]       hi_q;     // Bank of incremented address
   iccm_word_t [NUM_BANKS-1:0] dout_fn;
   logic [2*DATA_W-1:0]        pre;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lo_q <= '0;
         hi_q <= '0;
      end else if (rden) begin
         lo_q <= req_addr[BANK_BITS:0];
         hi_q <= inc_addr[BSEL_LO +: BANK_BITS];
      end
   end

   // **************************************************
   // Spare row override
   // **************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_fn
      assign dout_fn[i] = sel1_q[i] ? rows[1].data :
                          sel0_q[i] ? rows[0].data : bank_dout[i];
   end

   // Second word above first
   assign pre = {dout_fn[hi_q][DATA_W-1:0], dout_fn[lo_q[BANK_BITS:1]][DATA_W-1:0]};

   // Odd halfword drops the low half and zero fills on top
   assign rd_data = lo_q[0] ? {{(DATA_W/2){1'b0}}, pre[2*DATA_W-1:DATA_W/2]} : pre;
   assign rd_data_ecc = {dout_fn[hi_q], dout_fn[lo_q[BANK_BITS:1]]};  // Raw words

endmodule

`default_nettype wire

/* source/iccm_red_rows.sv */
// ICCM spare rows for hard faults
`default_nettype none

module iccm_red_rows
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = ICCM_BITS_DEF
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  iccm_req_t                  req,
   input  iccm_wdata_t                wr_data,
   input  logic      [ICCM_BITS-2:0]  inc_addr,
   output iccm_row_t [1:0]            rows,
   output logic      [NUM_BANKS-1:0]  sel0_q,   // Row 0 replaces bank
   output logic      [NUM_BANKS-1:0]  sel1_q    // Row 1 replaces bank
);

   logic                        lru;          // Next row to replace
   logic                        lru_en;
   logic                        lru_nxt;
   logic [1:0]                  valid_q;
   logic [1:0][ICCM_BITS-3:0]   waddr_q;
   iccm_word_t [1:0]            data_q;
   logic [ICCM_BITS-3:0]        req_waddr;
   logic [ICCM_BITS-3:0]        inc_waddr;
   logic [1:0]                  load;         // Correction into row
   logic [1:0]                  upd;          // Write through to row
   logic [1:0][NUM_BANKS-1:0]   sel;

   assign req_waddr = req.addr[ICCM_BITS-2:1];
   assign inc_waddr = inc_addr[ICCM_BITS-2:1];

   // **************************************************
   // Row match and update enables
   // **************************************************
   for (genvar r = 0; r < 2; r++) begin : g_row
      assign load[r] = req.correct & (lru == 1'(r));

      // DW covers both words of the 8 byte pair
      assign upd[r] = req.wren & valid_q[r] &
                      (req_waddr[ICCM_BITS-3:1] == waddr_q[r][ICCM_BITS-3:1]) &
                      ((req_waddr[0] == waddr_q[r][0]) | (req.size == SZ_DW));

      for (genvar i = 0; i < NUM_BANKS; i++) begin : g_sel
         assign sel[r][i] = valid_q[r] &
            (((req_waddr == waddr_q[r]) & (req_waddr[BANK_BITS-1:0] == BANK_BITS'(i))) |
             ((inc_waddr == waddr_q[r]) & (inc_waddr[BANK_BITS-1:0] == BANK_BITS'(i))));
      end
   end

   // Read hit in a correction steers LRU off the hit row
   assign lru_en = req.correct | ((|sel[0] | |sel[1]) & req.rden & req.corr_state);
   assign lru_nxt = req.correct ? ~lru : (|sel[0]);

   // **************************************************
   // Control flops
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lru     <= 1'b0;
         valid_q <= '0;
         sel0_q  <= '0;
         sel1_q  <= '0;
      end else begin
         if (lru_en) lru <= lru_nxt;
         for (int r = 0; r < 2; r++) begin
            if (load[r]) valid_q[r] <= 1'b1;
         end
         if (req.rden) begin
            sel0_q <= sel[0];  // Used on the data cycle
            sel1_q <= sel[1];
         end
      end
   end

   // Row address and data
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (load[r]) begin
            waddr_q[r] <= req_waddr;
            data_q[r]  <= wr_data.lo;       // Correction data is a single word
         end else if (upd[r]) begin
            data_q[r] <= waddr_q[r][0] ? wr_data.hi : wr_data.lo;
         end
      end
   end

   always_comb begin
      for (int r = 0; r < 2; r++) begin
         rows[r].valid = valid_q[r];
         rows[r].waddr = waddr_q[r];
         rows[r].data  = data_q[r];
      end
   end

endmodule

`default_nettype wire

/* vlog.f */
source/iccm_pkg.sv
source/iccm_bank.sv
source/iccm_bank_ctrl.sv
source/iccm_red_rows.sv
source/iccm_rd_align.sv
source/iccm_mem.sv
sim/iccm_mem_asserts.sv
sim/tb_iccm_mem.sv
